//--- source/lsu_pkg.sv
package lsu_pkg;

    // ######################################################################
    // Data path and addressing.
    // ######################################################################

    localparam int xlen        = 64;
    localparam int strb_w      = xlen / 8;
    localparam int word_addr_w = 16;
    localparam int byte_off_w  = $clog2(strb_w);      // Zero bits below a word address.
    localparam int bus_addr_w  = word_addr_w + byte_off_w;

    // Cache geometry, one word per line.
    localparam int cache_index_w = 4;
    localparam int cache_tag_w   = word_addr_w - cache_index_w;
    localparam int cache_lines   = 1 << cache_index_w;

    // RAM geometry and read timing.
    localparam int ram_words   = 1024;
    localparam int ram_index_w = $clog2(ram_words);
    localparam int mem_latency = 3;                   // Read accept to rvalid.
    localparam int lat_cnt_w   = $clog2(mem_latency + 1);

    // ######################################################################
    // Bus types.
    // ######################################################################

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axil_resp_e;

    // Master side.
    typedef struct packed {
        logic                  arvalid;
        logic [bus_addr_w-1:0] araddr;
        logic                  rready;
        logic                  awvalid;
        logic [bus_addr_w-1:0] awaddr;
        logic                  wvalid;
        logic [xlen-1:0]       wdata;
        logic [strb_w-1:0]     wstrb;
        logic                  bready;
    } axil_req_t;

    // Slave side.
    typedef struct packed {
        logic            arready;
        logic            rvalid;
        logic [xlen-1:0] rdata;
        axil_resp_e      rresp;
        logic            awready;
        logic            wready;
        logic            bvalid;
        axil_resp_e      bresp;
    } axil_rsp_t;

endpackage

//--- source/data_cache.sv
module data_cache
    import lsu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [word_addr_w-1:0] lookup_addr,
    input  logic                   fill_en,
    input  logic [word_addr_w-1:0] fill_addr,
    input  logic [xlen-1:0]        fill_data,
    output logic [xlen-1:0]        lookup_data,
    output logic                   lookup_hit
);

    logic [xlen-1:0]        data_mem [cache_lines];
    logic [cache_tag_w-1:0] tag_mem  [cache_lines];
    logic [cache_lines-1:0] valid;

    logic [cache_index_w-1:0] lookup_index;
    logic [cache_tag_w-1:0]   lookup_tag;
    logic [cache_index_w-1:0] fill_index;
    logic [cache_tag_w-1:0]   fill_tag;
    logic                     fill_bypass;

    assign lookup_index = lookup_addr[cache_index_w-1:0];
    assign lookup_tag   = lookup_addr[word_addr_w-1:cache_index_w];
    assign fill_index   = fill_addr[cache_index_w-1:0];
    assign fill_tag     = fill_addr[word_addr_w-1:cache_index_w];

    // Same line written this cycle.
    assign fill_bypass = fill_en && (fill_index == lookup_index);

    // ######################################################################
    // Line storage.
    // ######################################################################

    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_mem[fill_index] <= fill_data;
            tag_mem[fill_index]  <= fill_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (fill_en) begin
            valid[fill_index] <= 1'b1;
        end
    end

    // ######################################################################
    // Registered lookup.
    // ######################################################################

    always_ff @(posedge clk) begin
        if (fill_bypass) begin
            lookup_data <= fill_data;                  // New line wins.
        end else begin
            lookup_data <= data_mem[lookup_index];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lookup_hit <= 1'b0;
        end else if (fill_bypass) begin
            lookup_hit <= (fill_tag == lookup_tag);
        end else begin
            lookup_hit <= valid[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
        end
    end

endmodule

//--- source/load_store_unit.sv
module load_store_unit
    import lsu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   prev_stalled,
    input  logic                   do_load,
    input  logic                   do_store,
    input  logic [word_addr_w-1:0] addr,
    input  logic [xlen-1:0]        store_data,
    input  logic [strb_w-1:0]      store_mask,
    input  axil_rsp_t              bus_rsp,
    input  logic [xlen-1:0]        lookup_data,
    input  logic                   lookup_hit,
    output logic                   stall_next,
    output logic [xlen-1:0]        load_data,
    output logic                   access_fault,
    output axil_req_t              bus_req,
    output logic [word_addr_w-1:0] lookup_addr,
    output logic                   fill_en,
    output logic [word_addr_w-1:0] fill_addr,
    output logic [xlen-1:0]        fill_data
);

    typedef enum logic [2:0] {
        idle,
        load_check,
        load_pending,
        store_check,
        store_pending
    } lsu_state_e;

    lsu_state_e state;

    logic [word_addr_w-1:0] addr_buf;
    logic [xlen-1:0]        store_data_buf;
    logic [strb_w-1:0]      store_mask_buf;
    logic [xlen-1:0]        merged_data;

    logic issue_load;
    logic issue_store;
    logic can_accept;
    logic accept_load;
    logic accept_store;

    logic awvalid_q;
    logic wvalid_q;
    logic aw_done;
    logic w_done;
    logic ar_fire;
    logic aw_fire;
    logic w_fire;
    logic store_done;

    // ######################################################################
    // Request acceptance.
    // ######################################################################

    assign issue_load   = !prev_stalled && do_load && !do_store;
    assign issue_store  = !prev_stalled && do_store && !do_load;
    assign can_accept   = (state == idle) || !stall_next;
    assign accept_load  = can_accept && issue_load;
    assign accept_store = can_accept && issue_store;

    always_ff @(posedge clk) begin
        if (accept_load || accept_store) begin
            addr_buf       <= addr;
            store_data_buf <= store_data;
            store_mask_buf <= store_mask;
        end
    end

    // New request looks up straight from the pipeline.
    assign lookup_addr = (accept_load || accept_store) ? addr : addr_buf;

    // ######################################################################
    // Handshake tracking.
    // ######################################################################

    assign ar_fire    = bus_req.arvalid && bus_rsp.arready;
    assign aw_fire    = awvalid_q && bus_rsp.awready;
    assign w_fire     = wvalid_q && bus_rsp.wready;
    assign store_done = (aw_fire || aw_done) && (w_fire || w_done);

    always_ff @(posedge clk) begin
        if (rst) begin
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
        end else if (accept_store) begin
            awvalid_q <= 1'b1;
            wvalid_q  <= 1'b1;
        end else begin
            if (aw_fire) awvalid_q <= 1'b0;
            if (w_fire)  wvalid_q  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else if (store_done) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            if (aw_fire) aw_done <= 1'b1;
            if (w_fire)  w_done  <= 1'b1;
        end
    end

    // ######################################################################
    // State machine.
    // ######################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else if (can_accept) begin
            if (accept_load) begin
                state <= load_check;
            end else if (accept_store) begin
                state <= store_check;
            end else begin
                state <= idle;
            end
        end else begin
            case (state)
                load_check:  if (ar_fire) state <= load_pending;   // Miss sent.
                store_check: state <= store_pending;
                default:     state <= state;
            endcase
        end
    end

    always_comb begin
        case (state)
            load_check:    stall_next = !lookup_hit;
            load_pending:  stall_next = !bus_rsp.rvalid;
            store_check:   stall_next = !store_done;
            store_pending: stall_next = !store_done;
            default:       stall_next = 1'b1;
        endcase
    end

    assign load_data    = (state == load_pending) ? bus_rsp.rdata : lookup_data;
    assign access_fault = (state == load_pending) && bus_rsp.rvalid
                          && (bus_rsp.rresp != resp_okay);

    // ######################################################################
    // Cache update.
    // ######################################################################

    always_comb begin
        for (int i = 0; i < strb_w; i++) begin
            merged_data[i*8 +: 8] = store_mask_buf[i] ? store_data_buf[i*8 +: 8]
                                                      : lookup_data[i*8 +: 8];
        end
    end

    always_comb begin
        fill_en   = 1'b0;
        fill_data = bus_rsp.rdata;
        case (state)
            load_pending: fill_en = bus_rsp.rvalid && (bus_rsp.rresp == resp_okay);
            store_check: begin
                fill_en   = lookup_hit;                 // No allocate on store miss.
                fill_data = merged_data;
            end
            default: fill_en = 1'b0;
        endcase
    end

    assign fill_addr = addr_buf;

    // Bus drive.
    always_comb begin
        bus_req         = '0;
        bus_req.arvalid = (state == load_check) && !lookup_hit;
        bus_req.araddr  = {addr_buf, {byte_off_w{1'b0}}};
        bus_req.rready  = (state == load_pending);
        bus_req.awvalid = awvalid_q;
        bus_req.awaddr  = {addr_buf, {byte_off_w{1'b0}}};
        bus_req.wvalid  = wvalid_q;
        bus_req.wdata   = store_data_buf;
        bus_req.wstrb   = store_mask_buf;
        bus_req.bready  = 1'b1;
    end

endmodule

//--- source/axil_data_ram.sv
module axil_data_ram
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  axil_req_t bus_req,
    output axil_rsp_t bus_rsp
);

    logic [xlen-1:0] mem [ram_words];

    initial begin
        for (int i = 0; i < ram_words; i++) begin
            mem[i] = '0;
        end
    end

    logic [word_addr_w-1:0] rd_word;
    logic [word_addr_w-1:0] wr_word;
    logic                   rd_in_range;
    logic                   wr_in_range;
    logic                   ar_fire;
    logic                   wr_fire;

    logic                 rd_busy;
    logic [lat_cnt_w-1:0] rd_count;
    logic [xlen-1:0]      rd_data;
    axil_resp_e           rd_resp;
    logic                 bvalid_q;

    assign rd_word     = bus_req.araddr[bus_addr_w-1:byte_off_w];
    assign wr_word     = bus_req.awaddr[bus_addr_w-1:byte_off_w];
    assign rd_in_range = rd_word < ram_words;
    assign wr_in_range = wr_word < ram_words;

    // ######################################################################
    // Read channel with fixed latency.
    // ######################################################################

    assign ar_fire = bus_req.arvalid && bus_rsp.arready;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_busy  <= 1'b0;
            rd_count <= '0;
        end else if (ar_fire) begin
            rd_busy  <= 1'b1;
            rd_count <= lat_cnt_w'(mem_latency - 1);
        end else if (rd_busy) begin
            if (bus_rsp.rvalid && bus_req.rready) begin
                rd_busy <= 1'b0;
            end else if (rd_count != '0) begin
                rd_count <= rd_count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_data <= rd_in_range ? mem[rd_word[ram_index_w-1:0]] : '0;
            rd_resp <= rd_in_range ? resp_okay : resp_slverr;
        end
    end

    // ######################################################################
    // Write channel, aw and w taken together.
    // ######################################################################

    assign wr_fire = bus_req.awvalid && bus_req.wvalid && !bvalid_q;

    always @(posedge clk) begin
        if (wr_fire && wr_in_range) begin
            for (int i = 0; i < strb_w; i++) begin
                if (bus_req.wstrb[i]) mem[wr_word[ram_index_w-1:0]][i*8 +: 8] <=
                    bus_req.wdata[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid_q <= 1'b0;
        end else if (wr_fire) begin
            bvalid_q <= 1'b1;
        end else if (bus_req.bready) begin
            bvalid_q <= 1'b0;
        end
    end

    assign bus_rsp.arready = !rd_busy;
    assign bus_rsp.rvalid  = rd_busy && (rd_count == '0);
    assign bus_rsp.rdata   = rd_data;
    assign bus_rsp.rresp   = rd_resp;
    assign bus_rsp.awready = wr_fire;
    assign bus_rsp.wready  = wr_fire;
    assign bus_rsp.bvalid  = bvalid_q;
    assign bus_rsp.bresp   = resp_okay;     // Invalid writes are dropped.

endmodule

//--- source/mem_subsystem.sv
module mem_subsystem
    import lsu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   prev_stalled,
    input  logic                   do_load,
    input  logic                   do_store,
    input  logic [word_addr_w-1:0] addr,
    input  logic [xlen-1:0]        store_data,
    input  logic [strb_w-1:0]      store_mask,
    output logic                   stall_next,
    output logic [xlen-1:0]        load_data,
    output logic                   access_fault
);

    axil_req_t              bus_req;
    axil_rsp_t              bus_rsp;
    logic [word_addr_w-1:0] lookup_addr;
    logic [xlen-1:0]        lookup_data;
    logic                   lookup_hit;
    logic                   fill_en;
    logic [word_addr_w-1:0] fill_addr;
    logic [xlen-1:0]        fill_data;

    load_store_unit lsu (
        .clk          (clk),
        .rst          (rst),
        .prev_stalled (prev_stalled),
        .do_load      (do_load),
        .do_store     (do_store),
        .addr         (addr),
        .store_data   (store_data),
        .store_mask   (store_mask),
        .bus_rsp      (bus_rsp),
        .lookup_data  (lookup_data),
        .lookup_hit   (lookup_hit),
        .stall_next   (stall_next),
        .load_data    (load_data),
        .access_fault (access_fault),
        .bus_req      (bus_req),
        .lookup_addr  (lookup_addr),
        .fill_en      (fill_en),
        .fill_addr    (fill_addr),
        .fill_data    (fill_data)
    );

    data_cache dcache (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (lookup_addr),
        .fill_en     (fill_en),
        .fill_addr   (fill_addr),
        .fill_data   (fill_data),
        .lookup_data (lookup_data),
        .lookup_hit  (lookup_hit)
    );

    axil_data_ram ram (
        .clk     (clk),
        .rst     (rst),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

endmodule

//--- testbench/mem_subsystem_asserts.sv
module mem_subsystem_asserts
    import lsu_pkg::*;
(
    input logic                   clk,
    input logic                   rst,
    input logic                   prev_stalled,
    input logic                   do_load,
    input logic                   do_store,
    input logic [word_addr_w-1:0] addr,
    input logic [xlen-1:0]        store_data,
    input logic [strb_w-1:0]      store_mask,
    input logic                   stall_next,
    input logic [xlen-1:0]        load_data,
    input logic                   access_fault
);

    int mismatch_count = 0;
    int failure_count = 0;
    int loads_checked;
    int stores_checked;

    logic [xlen-1:0]        shadow [ram_words];
    logic [cache_lines-1:0] line_valid;                    // Expected cache contents.
    logic [cache_tag_w-1:0] line_tag [cache_lines];

    logic                   in_flight;
    logic                   op_store;
    logic [word_addr_w-1:0] op_addr;
    logic [xlen-1:0]        exp_data;
    logic                   exp_fault;
    logic                   exp_stretch;
    int                     exp_cycles;
    int                     wait_cycles;

    logic                     issue;
    logic                     load_done;
    logic                     store_done;
    logic                     in_range;
    logic                     model_hit;
    logic [cache_index_w-1:0] req_index;
    logic [cache_tag_w-1:0]   req_tag;

    function automatic logic [xlen-1:0] merge_bytes(
        input logic [xlen-1:0]   old_word,
        input logic [xlen-1:0]   new_word,
        input logic [strb_w-1:0] mask
    );
        logic [xlen-1:0] result;
        result = old_word;
        for (int i = 0; i < strb_w; i++) begin
            if (mask[i]) result[i*8 +: 8] = new_word[i*8 +: 8];
        end
        return result;
    endfunction

    assign load_done  = in_flight && !op_store && !stall_next;
    assign store_done = in_flight && op_store && !stall_next;
    assign issue      = !prev_stalled && (do_load != do_store) && (!in_flight || !stall_next);
    assign in_range   = addr < word_addr_w'(ram_words);
    assign req_index  = addr[cache_index_w-1:0];
    assign req_tag    = addr[word_addr_w-1:cache_index_w];
    assign model_hit  = line_valid[req_index] && (line_tag[req_index] == req_tag);

    // ######################################################################
    // Request tracking and shadow memory.
    // ######################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight      <= 1'b0;
            wait_cycles    <= 0;
            line_valid     <= '0;
            loads_checked  <= 0;
            stores_checked <= 0;
            for (int i = 0; i < ram_words; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            if (load_done) loads_checked <= loads_checked + 1;
            if (store_done) stores_checked <= stores_checked + 1;
            if (issue) begin
                in_flight   <= 1'b1;
                wait_cycles <= 1;
                op_store    <= do_store;
                op_addr     <= addr;
                if (do_store) begin
                    exp_stretch <= store_done;             // Previous b still pending.
                    if (in_range) begin
                        shadow[addr[ram_index_w-1:0]] <=
                            merge_bytes(shadow[addr[ram_index_w-1:0]], store_data, store_mask);
                    end
                end else begin
                    exp_data   <= in_range ? shadow[addr[ram_index_w-1:0]] : '0;
                    exp_fault  <= !in_range;
                    exp_cycles <= model_hit ? 1 : 1 + mem_latency;
                    if (in_range) begin
                        line_valid[req_index] <= 1'b1;
                        line_tag[req_index]   <= req_tag;
                    end
                end
            end else if (in_flight) begin
                if (!stall_next) in_flight <= 1'b0;
                wait_cycles <= wait_cycles + 1;
            end
        end
    end

    // ######################################################################
    // Checks.
    // ######################################################################

    a_idle_stall: assert property (@(posedge clk) disable iff (rst)
        !in_flight |-> stall_next)
        else begin
            failure_count++;
            $error("The unit is idle but stall_next is low at %0t", $time);
        end

    a_load_data: assert property (@(posedge clk) disable iff (rst)
        load_done |-> load_data == exp_data)
        else begin
            mismatch_count++;
            $error("Mismatch at %0t: load_data expected %h, actual %h", $time,
                   $sampled(exp_data), $sampled(load_data));
        end

    a_load_fault: assert property (@(posedge clk) disable iff (rst)
        load_done |-> access_fault == exp_fault)
        else begin
            mismatch_count++;
            $error("Mismatch at %0t: access_fault expected %b, actual %b", $time,
                   $sampled(exp_fault), $sampled(access_fault));
        end

    a_load_time: assert property (@(posedge clk) disable iff (rst)
        load_done |-> wait_cycles == exp_cycles)
        else begin
            failure_count++;
            $error("Load of word %h took %0d cycles instead of %0d", $sampled(op_addr),
                   $sampled(wait_cycles), $sampled(exp_cycles));
        end

    a_store_time: assert property (@(posedge clk) disable iff (rst)
        store_done && !exp_stretch |-> wait_cycles == 1)
        else begin
            failure_count++;
            $error("Store to word %h was stalled %0d cycles without back-pressure",
                   $sampled(op_addr), $sampled(wait_cycles));
        end

    a_store_stretch: assert property (@(posedge clk) disable iff (rst)
        store_done && exp_stretch |-> wait_cycles > 1)
        else begin
            failure_count++;
            $error("Store to word %h finished at once although a b response was pending",
                   $sampled(op_addr));
        end

endmodule

bind mem_subsystem mem_subsystem_asserts checks (
    .clk          (clk),
    .rst          (rst),
    .prev_stalled (prev_stalled),
    .do_load      (do_load),
    .do_store     (do_store),
    .addr         (addr),
    .store_data   (store_data),
    .store_mask   (store_mask),
    .stall_next   (stall_next),
    .load_data    (load_data),
    .access_fault (access_fault)
);

//--- testbench/tb_mem_subsystem.sv
module tb_mem_subsystem
    import lsu_pkg::*;
();

    localparam int max_op_cycles  = 1 + mem_latency;
    localparam int timeout_cycles = 400 * max_op_cycles + 200;
    localparam int random_ops     = 150;

    logic                   clk;
    logic                   rst;
    logic                   prev_stalled;
    logic                   do_load;
    logic                   do_store;
    logic [word_addr_w-1:0] addr;
    logic [xlen-1:0]        store_data;
    logic [strb_w-1:0]      store_mask;
    logic                   stall_next;
    logic [xlen-1:0]        load_data;
    logic                   access_fault;

    int seed;
    int total_errors;

    mem_subsystem dut (
        .clk          (clk),
        .rst          (rst),
        .prev_stalled (prev_stalled),
        .do_load      (do_load),
        .do_store     (do_store),
        .addr         (addr),
        .store_data   (store_data),
        .store_mask   (store_mask),
        .stall_next   (stall_next),
        .load_data    (load_data),
        .access_fault (access_fault)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
        $display(">>> FAIL");
        $finish;
    end

    // ######################################################################
    // Request tasks, entered 2 units after an edge.
    // ######################################################################

    // Returns in the cycle where the request finishes.
    task automatic run_op(input logic is_store, input logic [word_addr_w-1:0] word,
                          input logic [xlen-1:0] data, input logic [strb_w-1:0] mask);
        prev_stalled = 1'b0;
        do_load      = !is_store;
        do_store     = is_store;
        addr         = word;
        store_data   = data;
        store_mask   = mask;
        @(posedge clk);
        #2;
        do_load  = 1'b0;
        do_store = 1'b0;
        while (stall_next) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic load(input logic [word_addr_w-1:0] word);
        run_op(1'b0, word, '0, '0);
    endtask

    task automatic store_random(input logic [word_addr_w-1:0] word);
        logic [31:0]     rnd;
        logic [xlen-1:0] data;
        data = {$random(seed), $random(seed)};
        rnd  = $random(seed);
        run_op(1'b1, word, data, rnd[strb_w-1:0]);
    endtask

    // Load held off by prev_stalled.
    task automatic idle_cycles(input int n);
        repeat (n) begin
            prev_stalled = 1'b1;
            do_load      = 1'b1;
            @(posedge clk);
            #2;
        end
        prev_stalled = 1'b0;
        do_load      = 1'b0;
    endtask

    task automatic random_op();
        logic [31:0]            rnd;
        logic [word_addr_w-1:0] word;
        rnd  = $random(seed);
        word = word_addr_w'(rnd[5:0]);                     // 64 words, 4 tags per line.
        if (rnd[15:14] == 2'd0) idle_cycles(1 + int'(rnd[16]));
        if (rnd[12]) begin
            store_random(word);
        end else if (rnd[11:8] == 4'd0) begin
            load(word_addr_w'(ram_words) + word);
        end else begin
            load(word);
        end
    endtask

    // ######################################################################
    // Test sequence.
    // ######################################################################

    initial begin
        seed         = 32'hde54e1b1;
        rst          = 1'b1;
        prev_stalled = 1'b0;
        do_load      = 1'b0;
        do_store     = 1'b0;
        addr         = '0;
        store_data   = '0;
        store_mask   = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        idle_cycles(2);

        load(16'd5);                                       // Cold miss.
        load(16'd5);
        load(16'd40);
        store_random(16'd5);                               // Store hit.
        load(16'd5);
        store_random(16'd200);                             // Write-through only.
        load(16'd200);
        load(16'd200);

        idle_cycles(1);
        load(word_addr_w'(ram_words) + 16'd5);
        load(word_addr_w'(ram_words) + 16'd5);
        load(16'd5);

        for (int i = 0; i < 4; i++) begin
            load(16'd3);
            load(16'd19);
        end

        for (int i = 0; i < 6; i++) begin
            store_random(word_addr_w'(100 + i));
        end
        for (int i = 0; i < 6; i++) begin
            load(word_addr_w'(100 + i));
        end

        idle_cycles(1);
        store_random(16'd7);
        idle_cycles(1);
        load(16'd7);

        for (int i = 0; i < random_ops; i++) begin
            random_op();
        end
        idle_cycles(3);

        total_errors = dut.checks.mismatch_count + dut.checks.failure_count;
        $display("Checked %0d loads and %0d stores, %0d mismatches, %0d other errors",
                 dut.checks.loads_checked, dut.checks.stores_checked,
                 dut.checks.mismatch_count, dut.checks.failure_count);
        if (total_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- project.f
source/lsu_pkg.sv
source/data_cache.sv
source/load_store_unit.sv
source/axil_data_ram.sv
source/mem_subsystem.sv
testbench/mem_subsystem_asserts.sv
testbench/tb_mem_subsystem.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_mem_subsystem -o tb_mem_subsystem
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_mem_subsystem +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q -x ">>> PASS"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
